/* design/assigned_ovc_full_mask.sv */
`timescale 1ns/1ns

module assigned_ovc_full_mask
	import router_cfg_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  vc_vec_t       assigned_ovc,
	input  dest_vec_t     dest,
	input  dest_ovc_vec_t full,
	input  dest_ovc_vec_t nearly_full,
	input  dest_ovc_vec_t credit_in,
	input  logic          sw_grant,
	output logic          not_full
);

	dest_ovc_vec_t full_live;	// credit arriving now clears the flag
	dest_ovc_vec_t nf_live;
	vc_vec_t       port_full;
	vc_vec_t       port_nf;
	logic          sel_full;
	logic          sel_nf;
	logic          full_q;
	logic          nf_grant_q;

	assign full_live = full & ~credit_in;
	assign nf_live   = nearly_full & ~credit_in;

	// pick the dest port slice, dest is one-hot
	always_comb begin
		port_full = '0;
		port_nf   = '0;
		for (int d = 0; d < num_dest; d++) begin
			if (dest[d]) begin
				port_full = port_full | full_live[d*num_vc +: num_vc];
				port_nf   = port_nf | nf_live[d*num_vc +: num_vc];
			end
		end
	end

	assign sel_full = |(port_full & assigned_ovc);
	assign sel_nf   = |(port_nf & assigned_ovc);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			full_q     <= 1'b0;
			nf_grant_q <= 1'b0;
		end else begin
			full_q     <= sel_full;
			nf_grant_q <= sel_nf & sw_grant;	// last credit taken by this grant
		end
	end

	assign not_full = ~(full_q | nf_grant_q);

endmodule

/* design/credit_counter_top.sv */
`timescale 1ns/1ns

module credit_counter_top
	import router_cfg_pkg::*;
	import credit_types_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  inport_req_t req [num_port],
	input  ovc_vec_t    ovc_alloc,
	input  ovc_vec_t    credit_in,
	input  dest_vec_t   ivc_dest [num_ovc],
	input  ovc_vec_t    ivc_sw_grant,
	output ovc_vec_t    ovc_available,
	output ovc_vec_t    assigned_ovc_not_full
);

	dest_ovc_vec_t       used_port [num_port];	// dest-relative, per source port
	dest_ovc_vec_t       rel_port  [num_port];
	dest_ovc_vec_t       full_port [num_port];
	dest_ovc_vec_t       nf_port   [num_port];
	dest_ovc_vec_t       cin_port  [num_port];
	logic [num_dest-1:0] used_gen  [num_ovc];	// one bit per possible source port
	logic [num_dest-1:0] rel_gen   [num_ovc];
	ovc_vec_t            used_all;
	ovc_vec_t            rel_all;
	ovc_vec_t            full;
	ovc_vec_t            nearly_full;
	ovc_event_t          events;

	for (genvar i = 0; i < num_port; i++) begin : g_port
		inport_credit_decode u_decode (
			.req         (req[i]),
			.credit_used (used_port[i]),
			.released    (rel_port[i])
		);

		// absolute flags into port i's dest-relative order
		for (genvar j = 0; j < num_dest; j++) begin : g_slot
			localparam int p = (j < i) ? j : j + 1;
			assign full_port[i][j*num_vc +: num_vc] = full[p*num_vc +: num_vc];
			assign nf_port[i][j*num_vc +: num_vc]   = nearly_full[p*num_vc +: num_vc];
			assign cin_port[i][j*num_vc +: num_vc]  = credit_in[p*num_vc +: num_vc];
		end
	end

	// gather each output vc from every other source port
	for (genvar o = 0; o < num_port; o++) begin : g_out
		for (genvar i = 0; i < num_port; i++) begin : g_src
			if (i != o) begin : g_other
				localparam int j = (o < i) ? o : o - 1;	// slot of o seen from i
				localparam int s = (i < o) ? i : i - 1;	// slot of i seen from o
				for (genvar v = 0; v < num_vc; v++) begin : g_vc
					assign used_gen[o*num_vc+v][s] = used_port[i][j*num_vc+v];
					assign rel_gen[o*num_vc+v][s]  = rel_port[i][j*num_vc+v];
				end
			end
		end
	end

	for (genvar k = 0; k < num_ovc; k++) begin : g_ovc
		assign used_all[k] = |used_gen[k];
		assign rel_all[k]  = |rel_gen[k];

		assigned_ovc_full_mask u_mask (
			.clk          (clk),
			.reset        (reset),
			.assigned_ovc (req[k/num_vc].assigned_ovc_num[k%num_vc]),
			.dest         (ivc_dest[k]),
			.full         (full_port[k/num_vc]),
			.nearly_full  (nf_port[k/num_vc]),
			.credit_in    (cin_port[k/num_vc]),
			.sw_grant     (ivc_sw_grant[k]),
			.not_full     (assigned_ovc_not_full[k])
		);
	end

	assign events = '{credit_in: credit_in, credit_used: used_all, released: rel_all};

	ovc_credit_bank u_bank (
		.clk           (clk),
		.reset         (reset),
		.events        (events),
		.alloc         (ovc_alloc),
		.full          (full),
		.nearly_full   (nearly_full),
		.ovc_available (ovc_available)
	);

endmodule

/* design/credit_types_pkg.sv */
package credit_types_pkg;

	import router_cfg_pkg::*;

	// per-cycle counter update
	typedef enum logic [1:0] {
		cr_hold,
		cr_inc,
		cr_dec
	} credit_op_e;

	// output vc allocation state
	typedef enum logic {
		ovc_free,
		ovc_busy
	} ovc_state_e;

	// request bundle from one input port
	typedef struct packed {
		vc_vec_t               flit_is_tail;		// head-of-queue flit is a tail
		vc_vec_t               ovc_is_assigned;
		vc_vec_t [num_vc-1:0]  assigned_ovc_num;	// one-hot per input vc
		dest_vec_t             granted_dest_port;	// dest relative to this port
		vc_vec_t               granted_ivc;		// switch winner, one-hot
	} inport_req_t;

	// everything that touches the output vcs in one cycle
	typedef struct packed {
		ovc_vec_t credit_in;		// credit back from neighbour
		ovc_vec_t credit_used;		// flit leaving toward the vc
		ovc_vec_t released;		// tail flit leaving
	} ovc_event_t;

endpackage

/* design/inport_credit_decode.sv */
`timescale 1ns/1ns

module inport_credit_decode
	import router_cfg_pkg::*;
	import credit_types_pkg::*;
(
	input  inport_req_t   req,
	output dest_ovc_vec_t credit_used,
	output dest_ovc_vec_t released
);

	vc_vec_t sel_ovc;	// output vc of the granted input vc
	logic    sel_tail;

	// granted_ivc is one-hot, so an or-mux is enough
	always_comb begin
		sel_ovc  = '0;
		sel_tail = 1'b0;
		for (int i = 0; i < num_vc; i++) begin
			if (req.granted_ivc[i]) begin
				sel_ovc  = sel_ovc |
					(req.assigned_ovc_num[i] & {num_vc{req.ovc_is_assigned[i]}});
				sel_tail = sel_tail | req.flit_is_tail[i];
			end
		end
	end

	// steer the vc one-hot into the granted dest slot
	always_comb begin
		for (int d = 0; d < num_dest; d++) begin
			if (req.granted_dest_port[d]) begin
				credit_used[d*num_vc +: num_vc] = sel_ovc;
			end else begin
				credit_used[d*num_vc +: num_vc] = '0;
			end
		end
	end

	assign released = sel_tail ? credit_used : '0;	// tail frees the vc

endmodule

/* design/ovc_credit_bank.sv */
`timescale 1ns/1ns

module ovc_credit_bank
	import router_cfg_pkg::*;
	import credit_types_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  ovc_event_t events,
	input  ovc_vec_t   alloc,
	output ovc_vec_t   full,
	output ovc_vec_t   nearly_full,
	output ovc_vec_t   ovc_available
);

	credit_cnt_t cnt      [num_ovc];
	credit_cnt_t cnt_next [num_ovc];
	credit_op_e  op       [num_ovc];
	ovc_state_e  state    [num_ovc];
	ovc_vec_t    full_next;
	ovc_vec_t    nearly_full_next;
	ovc_vec_t    at_zero;
	ovc_vec_t    at_max;

	always_comb begin
		for (int k = 0; k < num_ovc; k++) begin
			// credit in and flit out together cancel
			case ({events.credit_in[k], events.credit_used[k]})
				2'b10:   op[k] = cr_inc;
				2'b01:   op[k] = cr_dec;
				default: op[k] = cr_hold;
			endcase
			case (op[k])
				cr_inc:  cnt_next[k] = cnt[k] + credit_cnt_t'(1);
				cr_dec:  cnt_next[k] = cnt[k] - credit_cnt_t'(1);
				default: cnt_next[k] = cnt[k];
			endcase
			full_next[k]        = (cnt_next[k] == '0);
			nearly_full_next[k] = (cnt_next[k] <= credit_cnt_t'(1));	// one flit may be in flight
			at_zero[k]          = (cnt[k] == '0);
			at_max[k]           = (cnt[k] == credit_cnt_t'(buf_depth));
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int k = 0; k < num_ovc; k++) begin
				cnt[k]   <= credit_cnt_t'(buf_depth);
				state[k] <= ovc_free;
			end
			full        <= '0;
			nearly_full <= '0;
		end else begin
			for (int k = 0; k < num_ovc; k++) begin
				cnt[k] <= cnt_next[k];
				if (events.released[k]) begin
					state[k] <= ovc_free;
				end
				if (alloc[k]) begin
					state[k] <= ovc_busy;
				end
			end
			full        <= full_next;
			nearly_full <= nearly_full_next;
		end
	end

	// non-atomic policy wants a free vc with two credits
	always_comb begin
		for (int k = 0; k < num_ovc; k++) begin
			ovc_available[k] = (state[k] == ovc_free) && !nearly_full[k];
		end
	end

	// switch allocation must have masked flits to an empty-credit vc
	a_no_overrun: assert property (@(posedge clk) disable iff (reset)
		(at_zero & events.credit_used & ~events.credit_in) == '0)
		else $error("flit sent to output vc with no credit");

	// neighbour returned more credits than the buffer holds
	a_no_excess_credit: assert property (@(posedge clk) disable iff (reset)
		(at_max & events.credit_in & ~events.credit_used) == '0)
		else $error("credit returned to output vc already at buf_depth");

	a_alloc_release: assert property (@(posedge clk) disable iff (reset)
		(alloc & events.released) == '0)
		else $error("output vc allocated and released in the same cycle");

endmodule

/* design/router_cfg_pkg.sv */
package router_cfg_pkg;

	// router geometry
	localparam int num_vc    = 4;	// vcs per port
	localparam int num_port  = 5;	// local plus four neighbours
	localparam int buf_depth = 4;	// flits per vc buffer

	// derived sizes
	localparam int num_dest = num_port - 1;	// every port but the source
	localparam int num_ovc  = num_vc * num_port;
	localparam int cnt_w    = 3;	// must hold buf_depth

	// one bit per vc of a single port
	typedef logic [num_vc-1:0] vc_vec_t;

	// one-hot over the other ports, ascending, source skipped
	typedef logic [num_dest-1:0] dest_vec_t;

	// one bit per output vc of the router
	typedef logic [num_ovc-1:0] ovc_vec_t;

	// all vcs of the other ports, dest slot major
	typedef logic [num_dest*num_vc-1:0] dest_ovc_vec_t;

	// credit counter value
	typedef logic [cnt_w-1:0] credit_cnt_t;

endpackage

/* dv/credit_checker.sv */
`timescale 1ns/1ns

module credit_checker
	import router_cfg_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         check_en,
	input  logic [127:0] step_name,
	input  ovc_vec_t     exp_avail,
	input  ovc_vec_t     exp_not_full,
	input  ovc_vec_t     ovc_available,
	input  ovc_vec_t     assigned_ovc_not_full,
	output int           errors,
	output int           checks
);

	logic bad_avail;
	logic bad_not_full;

	assign bad_avail    = check_en && (ovc_available !== exp_avail);
	assign bad_not_full = check_en && (assigned_ovc_not_full !== exp_not_full);

	// values seen here are the ones from before this edge
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			errors <= 0;
			checks <= 0;
		end else if (check_en) begin
			checks <= checks + 1;
			errors <= errors + int'(bad_avail) + int'(bad_not_full);
			if (bad_avail) begin
				$display("error: ovc_available after step %0s expected %h actual %h",
					step_name, exp_avail, ovc_available);
			end
			if (bad_not_full) begin
				$display("error: assigned_ovc_not_full after step %0s expected %h actual %h",
					step_name, exp_not_full, assigned_ovc_not_full);
			end
		end
	end

endmodule

/* dv/credit_counter_tb.sv */
`timescale 1ns/1ns

module credit_counter_tb
	import router_cfg_pkg::*;
	import credit_types_pkg::*;
();

	typedef logic [8*16-1:0] name_t;

	typedef struct packed {
		logic                    send;
		logic                    tail;
		logic [2:0]              src;
		logic [1:0]              ivc;
		logic [1:0]              slot;		// dest slot relative to src
		ovc_vec_t                alloc;
		ovc_vec_t                credit;
		ovc_vec_t                asg_valid;	// input vcs holding an output vc
		logic [num_ovc-1:0][1:0] asg_slot;
		logic [num_ovc-1:0][1:0] asg_vc;
		ovc_vec_t                exp_avail;
		ovc_vec_t                exp_not_full;
	} row_t;

	logic        clk;
	logic        reset;
	inport_req_t req [num_port];
	ovc_vec_t    ovc_alloc;
	ovc_vec_t    credit_in;
	dest_vec_t   ivc_dest [num_ovc];
	ovc_vec_t    ivc_sw_grant;
	ovc_vec_t    ovc_available;
	ovc_vec_t    assigned_ovc_not_full;
	logic        check_en;
	name_t       step_name;
	ovc_vec_t    exp_avail;
	ovc_vec_t    exp_not_full;
	int          errors;
	int          checks;
	bit          table_ready;
	row_t        rows [$];
	name_t       names [$];
	int          m_cnt [num_ovc];	// reference credit count
	bit          m_busy [num_ovc];
	bit          asg_v [num_ovc];
	int          asg_s [num_ovc];
	int          asg_c [num_ovc];
	int unsigned lcg_state = 44;

	credit_counter_top dut (
		.clk                   (clk),
		.reset                 (reset),
		.req                   (req),
		.ovc_alloc             (ovc_alloc),
		.credit_in             (credit_in),
		.ivc_dest              (ivc_dest),
		.ivc_sw_grant          (ivc_sw_grant),
		.ovc_available         (ovc_available),
		.assigned_ovc_not_full (assigned_ovc_not_full)
	);

	credit_checker u_check (
		.clk                   (clk),
		.reset                 (reset),
		.check_en              (check_en),
		.step_name             (step_name),
		.exp_avail             (exp_avail),
		.exp_not_full          (exp_not_full),
		.ovc_available         (ovc_available),
		.assigned_ovc_not_full (assigned_ovc_not_full),
		.errors                (errors),
		.checks                (checks)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic int next_rand(input int n);
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return int'((lcg_state >> 16) % 32'(n));
	endfunction

	task automatic add_row(input name_t name, input bit send, input bit tail, input int src,
		input int ivc, input int slot, input int vc, input int alloc_o, input int credit_o);
		row_t r;
		int   k;
		int   p;
		int   t;
		int   used;
		bit   cin;
		bit   hit_full;
		bit   hit_nf;
		r    = '0;
		k    = src * num_vc + ivc;
		used = -1;
		if (send) begin
			asg_v[k] = 1'b1;
			asg_s[k] = slot;
			asg_c[k] = vc;
			p        = (slot < src) ? slot : slot + 1;	// slot back to absolute port
			used     = p * num_vc + vc;
		end
		r.send = send;
		r.tail = tail;
		r.src  = 3'(src);
		r.ivc  = 2'(ivc);
		r.slot = 2'(slot);
		if (alloc_o >= 0) begin
			r.alloc[alloc_o] = 1'b1;
		end
		if (credit_o >= 0) begin
			r.credit[credit_o] = 1'b1;
		end
		// mask flops see the counts from before this row
		for (int n = 0; n < num_ovc; n++) begin
			r.asg_valid[n]    = asg_v[n];
			r.asg_slot[n]     = 2'(asg_s[n]);
			r.asg_vc[n]       = 2'(asg_c[n]);
			r.exp_not_full[n] = 1'b1;
			if (asg_v[n]) begin
				p                 = (asg_s[n] < n / num_vc) ? asg_s[n] : asg_s[n] + 1;
				t                 = p * num_vc + asg_c[n];
				cin               = r.credit[t];
				hit_full          = (m_cnt[t] == 0) && !cin;
				hit_nf            = (m_cnt[t] <= 1) && !cin && send && (n == k);
				r.exp_not_full[n] = !(hit_full || hit_nf);
			end
		end
		for (int n = 0; n < num_ovc; n++) begin
			if (n == used && !r.credit[n]) begin
				m_cnt[n]--;
			end else if (n != used && r.credit[n]) begin
				m_cnt[n]++;
			end
			if (n == used && tail) begin
				m_busy[n] = 1'b0;
			end
			if (r.alloc[n]) begin
				m_busy[n] = 1'b1;
			end
			r.exp_avail[n] = !m_busy[n] && (m_cnt[n] >= 2);
		end
		if (send && tail) begin
			asg_v[k] = 1'b0;
		end
		rows.push_back(r);
		names.push_back(name);
	endtask

	task automatic build_table();
		int o;
		int src;
		int p;
		int c;
		int a;
		bit send;
		bit tail;
		for (int n = 0; n < num_ovc; n++) begin
			m_cnt[n]  = buf_depth;
			m_busy[n] = 1'b0;
			asg_v[n]  = 1'b0;
			asg_s[n]  = 0;
			asg_c[n]  = 0;
		end
		add_row("idle", 0, 0, 0, 0, 0, 0, -1, -1);
		// ovc 9 is port 2 vc 1, slot 1 seen from port 0
		add_row("alloc_a", 0, 0, 0, 0, 0, 0, 9, -1);
		repeat (3) begin
			add_row("flit_a", 1, 0, 0, 0, 1, 1, -1, -1);
		end
		add_row("credit_a", 0, 0, 0, 0, 0, 0, -1, 9);
		// ovc 14 is port 3 vc 2, slot 2 seen from port 1
		add_row("alloc_b", 0, 0, 0, 0, 0, 0, 14, -1);
		repeat (4) begin
			add_row("flit_b", 1, 0, 1, 2, 2, 2, -1, -1);
		end
		repeat (2) begin
			add_row("wait_b", 0, 0, 0, 0, 0, 0, -1, -1);
		end
		add_row("credit_b", 0, 0, 0, 0, 0, 0, -1, 14);
		add_row("wait_b", 0, 0, 0, 0, 0, 0, -1, -1);
		add_row("tail_a", 1, 1, 0, 0, 1, 1, -1, -1);
		add_row("credit_a", 0, 0, 0, 0, 0, 0, -1, 9);
		add_row("alloc_a", 0, 0, 0, 0, 0, 0, 9, -1);
		add_row("flit_credit_a", 1, 0, 0, 0, 1, 1, -1, 9);
		add_row("tail_a", 1, 1, 0, 0, 1, 1, -1, -1);
		add_row("credit_a", 0, 0, 0, 0, 0, 0, -1, 9);
		for (int s = 0; s < 40; s++) begin
			o    = next_rand(num_ovc);
			p    = o / num_vc;
			src  = (p + 1 + next_rand(num_dest)) % num_port;	// never the dest port
			send = (next_rand(2) == 1) && (m_cnt[o] > 0);
			tail = send && (next_rand(4) == 0);
			c    = next_rand(num_ovc);
			if (m_cnt[c] == buf_depth && !(send && c == o)) begin
				c = -1;
			end
			a = next_rand(num_ovc);
			if (m_busy[a] || (tail && a == o)) begin
				a = -1;
			end
			add_row("soak", send, tail, src, next_rand(num_vc), (p < src) ? p : p - 1,
				o % num_vc, a, c);
		end
	endtask

	task automatic drive_row(input row_t r);
		int p;
		int v;
		int k;
		for (int i = 0; i < num_port; i++) begin
			req[i] = '0;
		end
		for (int n = 0; n < num_ovc; n++) begin
			p           = n / num_vc;
			v           = n % num_vc;
			ivc_dest[n] = '0;
			if (r.asg_valid[n]) begin
				req[p].ovc_is_assigned[v]  = 1'b1;
				req[p].assigned_ovc_num[v] = vc_vec_t'(1) << r.asg_vc[n];
				ivc_dest[n]                = dest_vec_t'(1) << r.asg_slot[n];
			end
		end
		ivc_sw_grant = '0;
		if (r.send) begin
			k                                = int'(r.src) * num_vc + int'(r.ivc);
			req[r.src].granted_ivc           = vc_vec_t'(1) << r.ivc;
			req[r.src].granted_dest_port     = dest_vec_t'(1) << r.slot;
			req[r.src].flit_is_tail[r.ivc]   = r.tail;
			ivc_sw_grant[k]                  = 1'b1;
		end
		ovc_alloc = r.alloc;
		credit_in = r.credit;
	endtask

	initial begin
		reset        = 1'b1;
		ovc_alloc    = '0;
		credit_in    = '0;
		ivc_sw_grant = '0;
		check_en     = 1'b0;
		step_name    = '0;
		exp_avail    = '0;
		exp_not_full = '0;
		for (int i = 0; i < num_port; i++) begin
			req[i] = '0;
		end
		for (int n = 0; n < num_ovc; n++) begin
			ivc_dest[n] = '0;
		end
		build_table();
		table_ready = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		// expectations trail the stimulus by one row
		for (int r = 0; r < rows.size(); r++) begin
			drive_row(rows[r]);
			if (r > 0) begin
				step_name    = names[r-1];
				exp_avail    = rows[r-1].exp_avail;
				exp_not_full = rows[r-1].exp_not_full;
				check_en     = 1'b1;
			end
			@(negedge clk);
		end
		drive_row('0);
		step_name    = names[$];
		exp_avail    = rows[$].exp_avail;
		exp_not_full = rows[$].exp_not_full;
		@(negedge clk);
		check_en = 1'b0;
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0 && checks == rows.size()) begin
			$display("** PASS **");
		end else begin
			if (checks != rows.size()) begin
				$display("not every table row was checked");
			end
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		wait (table_ready);
		#((rows.size() + 4 + 20) * 100);
		$display("timeout: the table did not finish in the expected number of cycles");
		$display("** FAIL **");
		$finish;
	end

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module credit_counter_tb -f sources.f -Mdir obj_dir
./obj_dir/Vcredit_counter_tb > sim.log 2>&1 || true
cat sim.log
if grep -qxF '** PASS **' sim.log; then
	exit 0
fi
echo "simulation did not pass"
exit 1

/* sources.f */
design/router_cfg_pkg.sv
design/credit_types_pkg.sv
design/inport_credit_decode.sv
design/ovc_credit_bank.sv
design/assigned_ovc_full_mask.sv
design/credit_counter_top.sv
dv/credit_checker.sv
dv/credit_counter_tb.sv
